//--- hw/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_XLEN        32
`define CSR_ADDR_W      12

// Machine CSR addresses.
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344
`define CSR_SATP        12'h180
`define CSR_MCYCLE      12'hB00
`define CSR_MHARTID     12'hF14

// Writable bits per register.
`define MSTATUS_MASK    32'h0000_1888  // MIE, MPIE, MPP.
`define MTVEC_MASK      32'hFFFF_FFFC  // Direct mode only.
`define MIP_MASK        32'h0000_0888

// mstatus field positions.
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7
`define MSTATUS_MPP_LO  11
`define MSTATUS_MPP_HI  12

// Privilege modes.
`define MODE_U          2'd0
`define MODE_M          2'd3

// Environment call causes, by calling mode.
`define CAUSE_ECALL_U   32'd8
`define CAUSE_ECALL_M   32'd11

`endif

//--- hw/csr_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    // One CSR value or one pc.
    typedef logic [`CSR_XLEN-1:0] csr_word_t;

    // CSR address as found in the instruction.
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Privilege mode, U or M here.
    typedef logic [1:0] priv_mode_t;

    // Read-modify-write kind, same codes as funct3[1:0].
    // Code 2'b00 is not used.
    typedef enum logic [1:0] {
        CSR_OP_RW = 2'b01,  // Swap.
        CSR_OP_RS = 2'b10,  // Set bits.
        CSR_OP_RC = 2'b11   // Clear bits.
    } csr_op_t;

    // Trap sequencing states.
    typedef enum logic [1:0] {
        ST_RUN  = 2'd0,
        ST_TRAP = 2'd1,     // Redirect to trap handler.
        ST_RET  = 2'd2      // Redirect to mepc.
    } trap_state_t;

endpackage

`default_nettype wire

//--- hw/csr_op_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit (
    input  logic               csr_commit,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_word_t csr_operand,
    input  csr_pkg::csr_word_t rdata,
    output logic               wr_en,
    output csr_pkg::csr_word_t wr_data
);

    import csr_pkg::*;

    logic operand_zero;

    // Set and clear with x0 or a zero immediate must not write.
    assign operand_zero = (csr_operand == '0);

    always_comb begin
        wr_data = rdata;
        wr_en   = 1'b0;
        case (csr_op)
            CSR_OP_RW: begin
                wr_data = csr_operand;
                wr_en   = csr_commit;
            end
            CSR_OP_RS: begin
                wr_data = rdata | csr_operand;
                wr_en   = csr_commit && !operand_zero;
            end
            CSR_OP_RC: begin
                wr_data = rdata & ~csr_operand;
                wr_en   = csr_commit && !operand_zero;
            end
            default: begin
                wr_data = rdata;  // Unused code, no write.
                wr_en   = 1'b0;
            end
        endcase
    end

    // Decode upstream only sends the three legal codes.
    always_comb begin
        if (csr_commit) begin
            assert (csr_op inside {CSR_OP_RW, CSR_OP_RS, CSR_OP_RC})
                else $error("csr_op_unit: illegal csr_op %0d on commit", csr_op);
        end
    end

endmodule

`default_nettype wire

//--- hw/cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               mcycle_load,
    input  csr_pkg::csr_word_t load_value,
    output csr_pkg::csr_word_t mcycle
);

    // A CSR write replaces the increment for that cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcycle <= '0;
        end else if (mcycle_load) begin
            mcycle <= load_value;
        end else begin
            mcycle <= mcycle + 1'b1;  // Wraps.
        end
    end

    // Free running between loads.
    assert property (
        @(posedge clk) disable iff (rst)
        !mcycle_load |=> (mcycle == $past(mcycle) + 32'd1)
    ) else $error("cycle_counter: mcycle did not advance by one");

endmodule

`default_nettype wire

//--- hw/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module trap_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                csr_valid,
    input  logic                ecall,
    input  logic                mret,
    input  csr_pkg::priv_mode_t saved_mpp,
    input  csr_pkg::csr_word_t  mtvec_base,
    input  csr_pkg::csr_word_t  mepc,
    output logic                trap_enter,
    output logic                trap_return,
    output logic                csr_commit,
    output logic                redirect_valid,
    output csr_pkg::csr_word_t  redirect_pc,
    output csr_pkg::priv_mode_t pmode
);

    import csr_pkg::*;

    trap_state_t state;
    trap_state_t state_next;
    csr_word_t   target;

    // ecall wins over mret, both win over a CSR instruction.
    assign trap_enter  = ecall;
    assign trap_return = mret && !ecall;
    assign csr_commit  = csr_valid && !ecall && !mret;

    // Every state arbitrates the same way, there is no back-pressure.
    always_comb begin
        if (trap_enter) begin
            state_next = ST_TRAP;
        end else if (trap_return) begin
            state_next = ST_RET;
        end else begin
            state_next = ST_RUN;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_RUN;
            pmode <= `MODE_M;
        end else begin
            state <= state_next;
            if (trap_enter) begin
                pmode <= `MODE_M;
            end else if (trap_return) begin
                pmode <= saved_mpp;
            end
        end
    end

    // Target captured with the strobe, shown during the redirect cycle.
    always_ff @(posedge clk) begin
        if (trap_enter) begin
            target <= mtvec_base;
        end else if (trap_return) begin
            target <= mepc;
        end
    end

    assign redirect_valid = (state == ST_TRAP) || (state == ST_RET);
    assign redirect_pc    = target;

    assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({trap_enter, trap_return, csr_commit})
    ) else $error("trap_ctrl: overlapping trap and CSR commits");

    // A redirect only ever follows a trap strobe by one cycle.
    assert property (
        @(posedge clk) disable iff (rst)
        redirect_valid |-> (state inside {ST_TRAP, ST_RET}) && $past(ecall || mret)
    ) else $error("trap_ctrl: redirect without a preceding ecall or mret");

endmodule

`default_nettype wire

//--- hw/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic                trap_enter,
    input  logic                trap_return,
    input  logic                wr_en,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::csr_word_t  wr_data,
    input  csr_pkg::csr_word_t  pc,
    input  csr_pkg::csr_word_t  mcycle,
    input  csr_pkg::priv_mode_t pmode,
    output csr_pkg::csr_word_t  rdata,
    output csr_pkg::csr_word_t  mtvec_base,
    output csr_pkg::csr_word_t  mepc,
    output csr_pkg::priv_mode_t saved_mpp,
    output logic                mcycle_load
);

    import csr_pkg::*;

    csr_word_t mstatus;
    csr_word_t mtvec;
    csr_word_t mip;
    csr_word_t mie;
    csr_word_t mscratch;
    csr_word_t mcause;
    csr_word_t mtval;
    csr_word_t mepc_q;
    csr_word_t satp;
    csr_word_t mstatus_wr;

    // Only U and M exist, so any other MPP value collapses to U.
    always_comb begin
        mstatus_wr = wr_data & `MSTATUS_MASK;
        if (mstatus_wr[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] != `MODE_M) begin
            mstatus_wr[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = `MODE_U;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mip      <= '0;
            mie      <= '0;
            mscratch <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mepc_q   <= '0;
            satp     <= '0;
        end else if (trap_enter) begin
            mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
            mstatus[`MSTATUS_MIE]  <= 1'b0;
            mstatus[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] <= pmode;
            mepc_q <= pc;
            mcause <= (pmode == `MODE_U) ? `CAUSE_ECALL_U : `CAUSE_ECALL_M;
        end else if (trap_return) begin
            mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
            mstatus[`MSTATUS_MPIE] <= 1'b1;
            mstatus[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] <= `MODE_U;
        end else if (wr_en) begin
            case (csr_addr)
                `CSR_MSTATUS:  mstatus  <= mstatus_wr;
                `CSR_MTVEC:    mtvec    <= wr_data & `MTVEC_MASK;
                `CSR_MIP:      mip      <= wr_data & `MIP_MASK;
                `CSR_MIE:      mie      <= wr_data;
                `CSR_MSCRATCH: mscratch <= wr_data;
                `CSR_MCAUSE:   mcause   <= wr_data;
                `CSR_MTVAL:    mtval    <= wr_data;
                `CSR_MEPC:     mepc_q   <= wr_data;
                `CSR_SATP:     satp     <= wr_data;
                default: begin
                    // mcycle lives in the counter, mhartid is read-only.
                end
            endcase
        end
    end

    // Old value, before this cycle's write.
    always_comb begin
        case (csr_addr)
            `CSR_MSTATUS:  rdata = mstatus;
            `CSR_MTVEC:    rdata = mtvec;
            `CSR_MIP:      rdata = mip;
            `CSR_MIE:      rdata = mie;
            `CSR_MSCRATCH: rdata = mscratch;
            `CSR_MCAUSE:   rdata = mcause;
            `CSR_MTVAL:    rdata = mtval;
            `CSR_MEPC:     rdata = mepc_q;
            `CSR_MCYCLE:   rdata = mcycle;
            `CSR_SATP:     rdata = satp;
            `CSR_MHARTID:  rdata = '0;  // Single hart.
            default:       rdata = '0;
        endcase
    end

    assign mcycle_load = wr_en && (csr_addr == `CSR_MCYCLE);
    assign mtvec_base  = mtvec;  // Low bits already cleared on write.
    assign mepc        = mepc_q;
    assign saved_mpp   = mstatus[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO];

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                csr_valid,
    input  csr_pkg::csr_op_t    csr_op,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::csr_word_t  csr_operand,
    input  logic                ecall,
    input  logic                mret,
    input  csr_pkg::csr_word_t  pc,
    output csr_pkg::csr_word_t  csr_rdata,
    output csr_pkg::priv_mode_t pmode,
    output logic                redirect_valid,
    output csr_pkg::csr_word_t  redirect_pc
);

    import csr_pkg::*;

    logic       trap_enter;
    logic       trap_return;
    logic       csr_commit;
    logic       wr_en;
    logic       mcycle_load;
    csr_word_t  wr_data;
    csr_word_t  mcycle;
    csr_word_t  mtvec_base;
    csr_word_t  mepc;
    priv_mode_t saved_mpp;

    trap_ctrl trap0 (
        .clk            (clk),
        .rst            (rst),
        .csr_valid      (csr_valid),
        .ecall          (ecall),
        .mret           (mret),
        .saved_mpp      (saved_mpp),
        .mtvec_base     (mtvec_base),
        .mepc           (mepc),
        .trap_enter     (trap_enter),
        .trap_return    (trap_return),
        .csr_commit     (csr_commit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pmode          (pmode)
    );

    csr_op_unit op0 (
        .csr_commit  (csr_commit),
        .csr_op      (csr_op),
        .csr_operand (csr_operand),
        .rdata       (csr_rdata),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    csr_regfile regs0 (
        .clk         (clk),
        .rst         (rst),
        .trap_enter  (trap_enter),
        .trap_return (trap_return),
        .wr_en       (wr_en),
        .csr_addr    (csr_addr),
        .wr_data     (wr_data),
        .pc          (pc),
        .mcycle      (mcycle),
        .pmode       (pmode),
        .rdata       (csr_rdata),
        .mtvec_base  (mtvec_base),
        .mepc        (mepc),
        .saved_mpp   (saved_mpp),
        .mcycle_load (mcycle_load)
    );

    cycle_counter cnt0 (
        .clk         (clk),
        .rst         (rst),
        .mcycle_load (mcycle_load),
        .load_value  (wr_data),
        .mcycle      (mcycle)
    );

endmodule

`default_nettype wire

//--- tb/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk
);

    localparam int HALF_NS = 2;  // 4 ns period.

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_unit_tb;

    import csr_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int TEST_CYCLES = 2500;  // Upper bound on all tests together.
    localparam int TIMEOUT_NS  = 2 * TEST_CYCLES * CLK_NS;

    localparam csr_addr_t IMPL_ADDRS [11] = '{
        `CSR_MSTATUS, `CSR_MTVEC, `CSR_MIP, `CSR_MIE, `CSR_MSCRATCH, `CSR_MCAUSE,
        `CSR_MTVAL, `CSR_MEPC, `CSR_MCYCLE, `CSR_MHARTID, `CSR_SATP
    };

    logic       clk;
    logic       rst;
    logic       csr_valid;
    csr_op_t    csr_op;
    csr_addr_t  csr_addr;
    csr_word_t  csr_operand;
    logic       ecall;
    logic       mret;
    csr_word_t  pc;
    csr_word_t  csr_rdata;
    priv_mode_t pmode;
    logic       redirect_valid;
    csr_word_t  redirect_pc;

    // Reference model.
    csr_word_t  m_mstatus;
    csr_word_t  m_mtvec;
    csr_word_t  m_mip;
    csr_word_t  m_mie;
    csr_word_t  m_mscratch;
    csr_word_t  m_mcause;
    csr_word_t  m_mtval;
    csr_word_t  m_mepc;
    csr_word_t  m_satp;
    priv_mode_t m_mode;
    csr_word_t  mc_base;         // mcycle value at cycle mc_ref.
    csr_word_t  mc_ref;
    csr_word_t  cycle_no;
    logic       redir_pending;
    csr_word_t  redir_target;
    csr_word_t  last_rdata;
    int         errors;

    clk_gen clk0 (.clk(clk));

    csr_unit dut0 (
        .clk            (clk),
        .rst            (rst),
        .csr_valid      (csr_valid),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_operand    (csr_operand),
        .ecall          (ecall),
        .mret           (mret),
        .pc             (pc),
        .csr_rdata      (csr_rdata),
        .pmode          (pmode),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_no <= '0;
        end else begin
            cycle_no <= cycle_no + 32'd1;
        end
    end

    task automatic check_equal(input string what, input csr_word_t exp, input csr_word_t act);
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", what, exp, act);
            errors++;
        end
    endtask

    function automatic csr_word_t expected_read(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS:  return m_mstatus;
            `CSR_MTVEC:    return m_mtvec;
            `CSR_MIP:      return m_mip;
            `CSR_MIE:      return m_mie;
            `CSR_MSCRATCH: return m_mscratch;
            `CSR_MCAUSE:   return m_mcause;
            `CSR_MTVAL:    return m_mtval;
            `CSR_MEPC:     return m_mepc;
            `CSR_SATP:     return m_satp;
            `CSR_MCYCLE:   return mc_base + (cycle_no - mc_ref);
            default:       return '0;  // mhartid and unimplemented.
        endcase
    endfunction

    task automatic model_write(input csr_addr_t addr, input csr_word_t data);
        csr_word_t st;
        st = data & `MSTATUS_MASK;
        // MPP codes 1 and 2 name modes that do not exist here.
        if (st[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] == 2'd1 ||
            st[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] == 2'd2) begin
            st[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = `MODE_U;
        end
        case (addr)
            `CSR_MSTATUS:  m_mstatus  = st;
            `CSR_MTVEC:    m_mtvec    = data & `MTVEC_MASK;
            `CSR_MIP:      m_mip      = data & `MIP_MASK;
            `CSR_MIE:      m_mie      = data;
            `CSR_MSCRATCH: m_mscratch = data;
            `CSR_MCAUSE:   m_mcause   = data;
            `CSR_MTVAL:    m_mtval    = data;
            `CSR_MEPC:     m_mepc     = data;
            `CSR_SATP:     m_satp     = data;
            `CSR_MCYCLE: begin
                mc_base = data;
                mc_ref  = cycle_no + 32'd1;  // Loaded at the coming edge.
            end
            default: begin
                // Read-only or absent.
            end
        endcase
    endtask

    // Drives one clock cycle of stimulus, checks it and then updates the model.
    task automatic step(input logic valid, input csr_op_t op, input csr_addr_t addr,
                        input csr_word_t operand, input logic ec, input logic mr,
                        input csr_word_t pc_val, input string tname);
        csr_word_t old;
        @(negedge clk);
        csr_valid   = valid;
        csr_op      = op;
        csr_addr    = addr;
        csr_operand = operand;
        ecall       = ec;
        mret        = mr;
        pc          = pc_val;
        #1;
        old        = expected_read(addr);
        last_rdata = csr_rdata;
        check_equal({tname, " redirect_valid"}, {31'd0, redir_pending}, {31'd0, redirect_valid});
        if (redir_pending) begin
            check_equal({tname, " redirect_pc"}, redir_target, redirect_pc);
        end
        check_equal({tname, " pmode"}, {30'd0, m_mode}, {30'd0, pmode});
        if (valid) begin
            check_equal({tname, " csr_rdata"}, old, csr_rdata);
        end
        if (ec) begin
            redir_pending = 1'b1;
            redir_target  = m_mtvec & ~32'h3;
            m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
            m_mstatus[`MSTATUS_MIE]  = 1'b0;
            m_mstatus[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = m_mode;
            m_mepc   = pc_val;
            m_mcause = (m_mode == `MODE_U) ? 32'd8 : 32'd11;
            m_mode   = `MODE_M;
        end else if (mr) begin
            redir_pending = 1'b1;
            redir_target  = m_mepc;
            m_mode = m_mstatus[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO];
            m_mstatus[`MSTATUS_MIE]  = m_mstatus[`MSTATUS_MPIE];
            m_mstatus[`MSTATUS_MPIE] = 1'b1;
            m_mstatus[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = `MODE_U;
        end else begin
            redir_pending = 1'b0;
            if (valid && op == CSR_OP_RW) begin
                model_write(addr, operand);
            end else if (valid && operand != '0) begin
                model_write(addr, (op == CSR_OP_RS) ? (old | operand) : (old & ~operand));
            end
        end
    endtask

    task automatic idle(input int n, input string tname);
        repeat (n) step(1'b0, CSR_OP_RW, '0, '0, 1'b0, 1'b0, '0, tname);
    endtask

    task automatic csr_access(input csr_op_t op, input csr_addr_t addr,
                              input csr_word_t operand, input string tname);
        step(1'b1, op, addr, operand, 1'b0, 1'b0, '0, tname);
    endtask

    task automatic read_csr(input csr_addr_t addr, input string tname);
        csr_access(CSR_OP_RS, addr, '0, tname);  // A zero operand does not write.
    endtask

    task automatic csr_rw_masks();
        csr_addr_t targets [4];
        targets = '{`CSR_MSCRATCH, `CSR_MSTATUS, `CSR_MTVEC, `CSR_MIP};
        foreach (IMPL_ADDRS[i]) read_csr(IMPL_ADDRS[i], "csr_rw_masks reset");
        foreach (targets[i]) begin
            csr_access(CSR_OP_RW, targets[i], 32'hFFFF_FFFF, "csr_rw_masks rw");
            read_csr(targets[i], "csr_rw_masks rw");
            csr_access(CSR_OP_RC, targets[i], 32'h5555_1008, "csr_rw_masks rc");
            read_csr(targets[i], "csr_rw_masks rc");
            csr_access(CSR_OP_RS, targets[i], 32'h0000_1003, "csr_rw_masks rs");
            csr_access(CSR_OP_RC, targets[i], '0, "csr_rw_masks rc zero");
            csr_access(CSR_OP_RW, targets[i], 32'h0000_1000, "csr_rw_masks rw mpp");
            read_csr(targets[i], "csr_rw_masks final");
        end
    endtask

    task automatic unimplemented_and_hartid();
        csr_access(CSR_OP_RW, 12'h7C0, 32'hDEAD_BEEF, "unimplemented_and_hartid");
        read_csr(12'h7C0, "unimplemented_and_hartid");
        check_equal("unimplemented_and_hartid absent", '0, last_rdata);
        csr_access(CSR_OP_RW, `CSR_MHARTID, 32'h1234_5678, "unimplemented_and_hartid");
        csr_access(CSR_OP_RS, `CSR_MHARTID, 32'hFFFF_FFFF, "unimplemented_and_hartid");
        read_csr(`CSR_MHARTID, "unimplemented_and_hartid");
        check_equal("unimplemented_and_hartid mhartid", '0, last_rdata);
        read_csr(`CSR_MSCRATCH, "unimplemented_and_hartid");
    endtask

    task automatic ecall_entry();
        csr_word_t epc;
        epc = $urandom & 32'hFFFF_FFFC;
        csr_access(CSR_OP_RW, `CSR_MSTATUS, 32'h0000_0008, "ecall_entry");
        csr_access(CSR_OP_RW, `CSR_MTVEC, 32'h8000_0107, "ecall_entry");
        step(1'b0, CSR_OP_RW, '0, '0, 1'b1, 1'b0, epc, "ecall_entry");
        idle(1, "ecall_entry redirect");
        read_csr(`CSR_MEPC, "ecall_entry");
        check_equal("ecall_entry mepc", epc, last_rdata);
        read_csr(`CSR_MCAUSE, "ecall_entry");
        check_equal("ecall_entry mcause", 32'd11, last_rdata);
        read_csr(`CSR_MSTATUS, "ecall_entry");
        check_equal("ecall_entry mstatus", 32'h0000_1880, last_rdata);  // MPIE, MPP=M.
    endtask

    task automatic mret_return();
        csr_word_t epc;
        epc = $urandom & 32'hFFFF_FFFC;
        csr_access(CSR_OP_RW, `CSR_MSTATUS, 32'h0000_0080, "mret_return");
        csr_access(CSR_OP_RW, `CSR_MEPC, epc, "mret_return");
        step(1'b0, CSR_OP_RW, '0, '0, 1'b0, 1'b1, '0, "mret_return");
        idle(1, "mret_return redirect");
        check_equal("mret_return pmode", {30'd0, `MODE_U}, {30'd0, pmode});
        read_csr(`CSR_MSTATUS, "mret_return");
        check_equal("mret_return mstatus", 32'h0000_0088, last_rdata);
        step(1'b0, CSR_OP_RW, '0, '0, 1'b1, 1'b0, epc + 32'd4, "mret_return ecall");
        idle(1, "mret_return ecall redirect");
        read_csr(`CSR_MCAUSE, "mret_return");
        check_equal("mret_return mcause", 32'd8, last_rdata);
        read_csr(`CSR_MSTATUS, "mret_return");
        check_equal("mret_return mstatus after ecall", 32'h0000_0080, last_rdata);
    endtask

    task automatic mcycle_count();
        csr_word_t first;
        csr_word_t v;
        int        k;
        k = 5 + int'($urandom % 8);
        read_csr(`CSR_MCYCLE, "mcycle_count");
        first = last_rdata;
        idle(k - 1, "mcycle_count");
        read_csr(`CSR_MCYCLE, "mcycle_count");
        check_equal("mcycle_count delta", csr_word_t'(k), last_rdata - first);
        v = $urandom;
        csr_access(CSR_OP_RW, `CSR_MCYCLE, v, "mcycle_count write");
        idle(1, "mcycle_count");
        read_csr(`CSR_MCYCLE, "mcycle_count");
        check_equal("mcycle_count loaded", v + 32'd1, last_rdata);
        csr_access(CSR_OP_RW, `CSR_MCYCLE, 32'hFFFF_FFFF, "mcycle_count wrap");
        idle(2, "mcycle_count wrap");
        read_csr(`CSR_MCYCLE, "mcycle_count wrap");
    endtask

    task automatic random_sequence();
        int        sel;
        csr_op_t   op;
        csr_word_t operand;
        for (int i = 0; i < 200; i++) begin
            sel = int'($urandom % 3);
            op  = (sel == 0) ? CSR_OP_RW : ((sel == 1) ? CSR_OP_RS : CSR_OP_RC);
            operand = (($urandom % 8) == 0) ? '0 : $urandom;
            sel = int'($urandom % 16);  // Rare traps and sometimes both strobes.
            step(($urandom % 4) != 0, op, IMPL_ADDRS[$urandom % 11], operand,
                 sel == 0 || sel == 2, sel == 1 || sel == 2, $urandom & 32'hFFFF_FFFC,
                 "random_sequence");
        end
        idle(2, "random_sequence");
    endtask

    initial begin
        void'($urandom(32'h6461_be46));
        errors        = 0;
        rst           = 1'b1;
        csr_valid     = 1'b0;
        csr_op        = CSR_OP_RW;
        csr_addr      = '0;
        csr_operand   = '0;
        ecall         = 1'b0;
        mret          = 1'b0;
        pc            = '0;
        m_mstatus     = '0;
        m_mtvec       = '0;
        m_mip         = '0;
        m_mie         = '0;
        m_mscratch    = '0;
        m_mcause      = '0;
        m_mtval       = '0;
        m_mepc        = '0;
        m_satp        = '0;
        m_mode        = `MODE_M;
        mc_base       = '0;
        mc_ref        = '0;
        redir_pending = 1'b0;
        redir_target  = '0;
        last_rdata    = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        csr_rw_masks();
        unimplemented_and_hartid();
        ecall_entry();
        mret_return();
        mcycle_count();
        random_sequence();

        $display("Checks failed: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_op_unit.sv
hw/cycle_counter.sv
hw/trap_ctrl.sv
hw/csr_regfile.sv
hw/csr_unit.sv
tb/clk_gen.sv
tb/csr_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the CSR unit testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module csr_unit_tb \
    -o csr_unit_sim

out=$(./obj_dir/csr_unit_sim)
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
